/* hash2qid_top.f */
hw/hash2qid_pkg.sv
hw/hash2qid_regs.sv
hw/hash2qid_in_stage.sv
hw/hash2qid_lookup.sv
hw/hash2qid_out_stage.sv
hw/hash2qid_top.sv
testbench/hash2qid_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the hash2qid testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=hash2qid_tb
OBJ=obj_dir
BIN=sim_hash2qid

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir "$OBJ" -o "$BIN" \
    -f hash2qid_top.f || { echo "Verilator build failed"; exit 1; }

sim_out=$("./$OBJ/$BIN")
echo "$sim_out"

echo "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

/* testbench/hash2qid_tb.sv */
`timescale 1ns/1ps

module hash2qid_tb
    import hash2qid_pkg::*;
();

    localparam int DATA_WID    = 64;
    localparam int CLK_HALF    = 5;
    localparam int MULTI_PKTS  = 48;
    localparam int LAT_PKTS    = 40;
    localparam int REPROG_PKTS = 32;
    // Worst case beat count over all tests
    localparam int TOTAL_BEATS = 256 + 256 + MULTI_PKTS * 8 + LAT_PKTS * 4 + REPROG_PKTS;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 2000;

    logic                  core_clk;
    logic                  arst_n;
    logic                  reg_wr_en;
    logic [REG_ADDR_WID-1:0] reg_wr_addr;
    logic [QID_WID-1:0]    reg_wr_data;
    logic                  in_valid;
    logic [DATA_WID-1:0]   in_data;
    logic                  in_last;
    logic                  in_rss_enable;
    logic [QID_WID-1:0]    in_rss_entropy;
    logic                  out_valid;
    logic [DATA_WID-1:0]   out_data;
    logic                  out_last;
    logic                  out_rss_enable;
    logic [QID_WID-1:0]    out_rss_entropy;

    // Reference copy of the programmed configuration
    logic [QID_WID-1:0]    base_ref [NUM_FUNCS];
    logic [QID_WID-1:0]    tbl_ref [TBL_DEPTH];

    // Expected beats, oldest first
    logic [DATA_WID-1:0]   exp_data [$];
    logic                  exp_last [$];
    logic [QID_WID-1:0]    exp_qid [$];
    int                    exp_cyc [$];

    logic [DATA_WID-1:0]   e_data;
    logic                  e_last;
    logic [QID_WID-1:0]    e_qid;
    int                    e_cyc;

    int    cyc;
    int    err_count;
    int    beats_checked;
    int    tests_run;
    int    tests_failed;
    int    test_err_base;
    int    test_beat_base;
    string test_name;

    hash2qid_top #(
        .DATA_WID (DATA_WID)
    ) dut (
        .core_clk        (core_clk),
        .arst_n          (arst_n),
        .reg_wr_en       (reg_wr_en),
        .reg_wr_addr     (reg_wr_addr),
        .reg_wr_data     (reg_wr_data),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_last         (in_last),
        .in_rss_enable   (in_rss_enable),
        .in_rss_entropy  (in_rss_entropy),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_last        (out_last),
        .out_rss_enable  (out_rss_enable),
        .out_rss_entropy (out_rss_entropy)
    );

    always #CLK_HALF core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cyc <= cyc + 1;
    end

    // ==================================================
    // Reference model and helpers
    // ==================================================

    function automatic logic [QID_WID-1:0] expected_qid(input logic rss_en,
                                                        input logic [QID_WID-1:0] ent);
        logic [FUNC_WID-1:0] f;
        logic [IDX_WID-1:0]  idx;
        f   = ent[11:10];
        idx = ent[6:0];
        if (rss_en) begin
            return base_ref[f] + tbl_ref[{f, idx}];
        end else begin
            return base_ref[f];
        end
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("ERR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        err_count = err_count + 1;
    endtask

    task automatic write_reg(input logic [REG_ADDR_WID-1:0] addr,
                             input logic [QID_WID-1:0] data);
        @(posedge core_clk);
        reg_wr_en   <= 1'b1;
        reg_wr_addr <= addr;
        reg_wr_data <= data;
    endtask

    task automatic program_base(input int f, input logic [QID_WID-1:0] val);
        write_reg({1'b1, 7'd0, f[1:0]}, val);
        base_ref[f] = val;
    endtask

    task automatic program_entry(input int f, input int j, input logic [QID_WID-1:0] val);
        write_reg({1'b0, f[1:0], j[6:0]}, val);
        tbl_ref[{f[1:0], j[6:0]}] = val;
    endtask

    // Base gets ~f in 11:10, entry gets ~f in 9:8 and ~j in 6:0
    task automatic program_tables();
        for (int f = 0; f < NUM_FUNCS; f++) begin
            program_base(f, {~f[1:0], 10'd0});
            for (int j = 0; j < (1 << IDX_WID); j++) begin
                program_entry(f, j, {2'b00, ~f[1:0], 1'b0, ~j[6:0]});
            end
        end
        @(posedge core_clk);
        reg_wr_en <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge core_clk);
        in_valid <= 1'b0;
    endtask

    // Later beats carry junk metadata, which the DUT must ignore
    task automatic send_packet(input int len, input logic rss_en,
                               input logic [QID_WID-1:0] entropy);
        logic [QID_WID-1:0]  qid;
        logic [DATA_WID-1:0] data;
        logic [31:0]         r32;
        qid = expected_qid(rss_en, entropy);
        for (int b = 0; b < len; b++) begin
            data = {$urandom, $urandom};
            r32  = $urandom;
            @(posedge core_clk);
            in_valid       <= 1'b1;
            in_data        <= data;
            in_last        <= (b == len - 1);
            in_rss_enable  <= (b == 0) ? rss_en : r32[12];
            in_rss_entropy <= (b == 0) ? entropy : r32[11:0];
            exp_data.push_back(data);
            exp_last.push_back(b == len - 1);
            exp_qid.push_back(qid);
            exp_cyc.push_back(cyc + 1);
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_base  = err_count;
        test_beat_base = beats_checked;
    endtask

    task automatic end_test();
        int errs;
        idle_cycle();
        while (exp_qid.size() != 0) begin
            @(posedge core_clk);
        end
        repeat (4) @(posedge core_clk);
        errs = err_count - test_err_base;
        $display("test %s: %0d beats checked, %0d errors", test_name,
                 beats_checked - test_beat_base, errs);
        tests_run = tests_run + 1;
        if (errs != 0) begin
            tests_failed = tests_failed + 1;
        end
    endtask

    // ==================================================
    // Output checks
    // ==================================================

    always @(negedge core_clk) begin
        if (out_valid) begin
            if (exp_qid.size() == 0) begin
                $display("%s: output beat appeared with no input beat outstanding", test_name);
                err_count = err_count + 1;
            end else begin
                e_data = exp_data.pop_front();
                e_last = exp_last.pop_front();
                e_qid  = exp_qid.pop_front();
                e_cyc  = exp_cyc.pop_front();
                beats_checked = beats_checked + 1;
                assert (out_rss_entropy == e_qid)
                    else report_mismatch("qid", 64'(e_qid), 64'(out_rss_entropy));
                assert (out_rss_enable == 1'b1)
                    else report_mismatch("rss_enable", 64'(1), 64'(out_rss_enable));
                assert (out_data == e_data)
                    else report_mismatch("data", e_data, out_data);
                assert (out_last == e_last)
                    else report_mismatch("last", 64'(e_last), 64'(out_last));
                assert (cyc - e_cyc == 4)
                    else report_mismatch("latency", 64'(4), 64'(cyc - e_cyc));
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 2 * CLK_HALF);
        $display("Timeout after %0d cycles, output beats stopped arriving", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [31:0] r32;
        int          len;
        void'($urandom(64369));
        core_clk       = 1'b0;
        arst_n         = 1'b0;
        reg_wr_en      = 1'b0;
        reg_wr_addr    = '0;
        reg_wr_data    = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_last        = 1'b0;
        in_rss_enable  = 1'b0;
        in_rss_entropy = '0;
        cyc            = 0;
        err_count      = 0;
        beats_checked  = 0;
        tests_run      = 0;
        tests_failed   = 0;

        // Output must stay idle through reset and table setup
        start_test("reset");
        repeat (3) @(posedge core_clk);
        arst_n <= 1'b1;
        program_tables();
        repeat (8) @(posedge core_clk);
        end_test();

        start_test("rss_enabled");
        for (int i = 0; i < 256; i++) begin
            r32 = $urandom;
            send_packet(1, 1'b1, r32[11:0]);
            if (r32[31:30] == 2'b00) begin
                idle_cycle();
            end
        end
        end_test();

        start_test("rss_disabled");
        for (int i = 0; i < 256; i++) begin
            r32 = $urandom;
            send_packet(1, 1'b0, r32[11:0]);
            if (r32[31:30] == 2'b00) begin
                idle_cycle();
            end
        end
        end_test();

        start_test("multi_beat");
        for (int i = 0; i < MULTI_PKTS; i++) begin
            r32 = $urandom;
            len = 1 + int'(r32[18:16]);
            send_packet(len, r32[20], r32[11:0]);
        end
        end_test();

        // Every cycle carries a beat, four in flight at once
        start_test("latency");
        for (int i = 0; i < LAT_PKTS; i++) begin
            r32 = $urandom;
            send_packet(4, 1'b1, r32[11:0]);
        end
        end_test();

        start_test("reprogram");
        program_entry(1, 5, 12'h0a5);
        program_base(2, 12'h123);
        @(posedge core_clk);
        reg_wr_en <= 1'b0;
        repeat (4) @(posedge core_clk);
        for (int i = 0; i < REPROG_PKTS; i++) begin
            r32 = $urandom;
            case (i % 4)
                0:       send_packet(1, 1'b1, {2'b01, 3'b000, 7'd5});
                1:       send_packet(1, 1'b1, {2'b10, r32[9:0]});
                2:       send_packet(1, 1'b0, {2'b10, r32[9:0]});
                default: send_packet(1, r32[12], r32[11:0]);
            endcase
        end
        end_test();

        $display("tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, beats_checked, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* hw/hash2qid_top.sv */
`timescale 1ns/1ps

module hash2qid_top
    import hash2qid_pkg::*;
#(
    parameter int DATA_WID = 64
) (
    input  logic                      core_clk,
    input  logic                      arst_n,

    // Register writes
    input  logic                      reg_wr_en,
    input  logic [REG_ADDR_WID-1:0]   reg_wr_addr,
    input  logic [QID_WID-1:0]        reg_wr_data,

    // Beat input
    input  logic                      in_valid,
    input  logic [DATA_WID-1:0]       in_data,
    input  logic                      in_last,
    input  logic                      in_rss_enable,
    input  logic [QID_WID-1:0]        in_rss_entropy,

    // Beat output
    output logic                      out_valid,
    output logic [DATA_WID-1:0]       out_data,
    output logic                      out_last,
    output logic                      out_rss_enable,
    output logic [QID_WID-1:0]        out_rss_entropy
);

    logic [NUM_FUNCS-1:0][QID_WID-1:0]   base_qid;
    logic                                tbl_wr_en;
    logic [TBL_ADDR_WID-1:0]             tbl_wr_addr;
    logic [QID_WID-1:0]                  tbl_wr_data;

    logic                  s1_valid;
    logic [DATA_WID-1:0]   s1_data;
    logic                  s1_last;
    logic                  s1_sop;
    logic                  s1_rss_enable;
    logic [QID_WID-1:0]    s1_entropy;

    logic                  s3_valid;
    logic [DATA_WID-1:0]   s3_data;
    logic                  s3_last;
    logic                  s3_sop;
    logic [QID_WID-1:0]    s3_qid;

    // ================================================
    // Input side
    // ================================================

    hash2qid_regs u_regs (
        .core_clk    (core_clk),
        .arst_n      (arst_n),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .base_qid    (base_qid),
        .tbl_wr_en   (tbl_wr_en),
        .tbl_wr_addr (tbl_wr_addr),
        .tbl_wr_data (tbl_wr_data)
    );

    hash2qid_in_stage #(
        .DATA_WID (DATA_WID)
    ) u_in_stage (
        .core_clk       (core_clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_last        (in_last),
        .in_rss_enable  (in_rss_enable),
        .in_rss_entropy (in_rss_entropy),
        .s1_valid       (s1_valid),
        .s1_data        (s1_data),
        .s1_last        (s1_last),
        .s1_sop         (s1_sop),
        .s1_rss_enable  (s1_rss_enable),
        .s1_entropy     (s1_entropy)
    );

    // ================================================
    // Lookup and output side
    // ================================================

    hash2qid_lookup #(
        .DATA_WID (DATA_WID)
    ) u_lookup (
        .core_clk      (core_clk),
        .arst_n        (arst_n),
        .base_qid      (base_qid),
        .tbl_wr_en     (tbl_wr_en),
        .tbl_wr_addr   (tbl_wr_addr),
        .tbl_wr_data   (tbl_wr_data),
        .s1_valid      (s1_valid),
        .s1_data       (s1_data),
        .s1_last       (s1_last),
        .s1_sop        (s1_sop),
        .s1_rss_enable (s1_rss_enable),
        .s1_entropy    (s1_entropy),
        .s3_valid      (s3_valid),
        .s3_data       (s3_data),
        .s3_last       (s3_last),
        .s3_sop        (s3_sop),
        .s3_qid        (s3_qid)
    );

    hash2qid_out_stage #(
        .DATA_WID (DATA_WID)
    ) u_out_stage (
        .core_clk        (core_clk),
        .arst_n          (arst_n),
        .s3_valid        (s3_valid),
        .s3_data         (s3_data),
        .s3_last         (s3_last),
        .s3_sop          (s3_sop),
        .s3_qid          (s3_qid),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_last        (out_last),
        .out_rss_enable  (out_rss_enable),
        .out_rss_entropy (out_rss_entropy)
    );

endmodule

/* hw/hash2qid_out_stage.sv */
`timescale 1ns/1ps

module hash2qid_out_stage
    import hash2qid_pkg::*;
#(
    parameter int DATA_WID = 64
) (
    input  logic                  core_clk,
    input  logic                  arst_n,

    input  logic                  s3_valid,
    input  logic [DATA_WID-1:0]   s3_data,
    input  logic                  s3_last,
    input  logic                  s3_sop,
    input  logic [QID_WID-1:0]    s3_qid,

    output logic                  out_valid,
    output logic [DATA_WID-1:0]   out_data,
    output logic                  out_last,
    output logic                  out_rss_enable,
    output logic [QID_WID-1:0]    out_rss_entropy
);

    // Queue id of the packet in progress
    logic [QID_WID-1:0] qid_hold;
    logic [QID_WID-1:0] qid_cur;

    // First beat uses its own result directly
    assign qid_cur = s3_sop ? s3_qid : qid_hold;

    always_ff @(posedge core_clk) begin
        if (s3_valid && s3_sop) begin
            qid_hold <= s3_qid;
        end
    end

    // ================================================
    // Output register
    // ================================================

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid      <= 1'b0;
            out_rss_enable <= 1'b0;
        end else begin
            out_valid <= s3_valid;
            if (s3_valid) begin
                out_rss_enable <= 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        out_data        <= s3_data;
        out_last        <= s3_last;
        out_rss_entropy <= qid_cur;
    end

endmodule

/* hw/hash2qid_lookup.sv */
`timescale 1ns/1ps

module hash2qid_lookup
    import hash2qid_pkg::*;
#(
    parameter int DATA_WID = 64
) (
    input  logic                                core_clk,
    input  logic                                arst_n,

    input  logic [NUM_FUNCS-1:0][QID_WID-1:0]   base_qid,

    input  logic                                tbl_wr_en,
    input  logic [TBL_ADDR_WID-1:0]             tbl_wr_addr,
    input  logic [QID_WID-1:0]                  tbl_wr_data,

    input  logic                                s1_valid,
    input  logic [DATA_WID-1:0]                 s1_data,
    input  logic                                s1_last,
    input  logic                                s1_sop,
    input  logic                                s1_rss_enable,
    input  logic [QID_WID-1:0]                  s1_entropy,

    output logic                                s3_valid,
    output logic [DATA_WID-1:0]                 s3_data,
    output logic                                s3_last,
    output logic                                s3_sop,
    output logic [QID_WID-1:0]                  s3_qid
);

    // PF, VF0, VF1, VF2 tables stacked by function
    logic [QID_WID-1:0]        tbl_mem [TBL_DEPTH];

    logic [FUNC_WID-1:0]       rd_func;
    logic [TBL_ADDR_WID-1:0]   rd_addr;

    logic                      s2_valid;
    logic [DATA_WID-1:0]       s2_data;
    logic                      s2_last;
    logic                      s2_sop;
    logic                      s2_rss_enable;
    logic [FUNC_WID-1:0]       s2_func;
    logic [QID_WID-1:0]        s2_entry;

    assign rd_func = s1_entropy[ENT_FUNC_LSB +: FUNC_WID];
    assign rd_addr = {rd_func, s1_entropy[ENT_IDX_LSB +: IDX_WID]};

    // ================================================
    // Stage 1, table write and registered read
    // ================================================

    always_ff @(posedge core_clk) begin
        if (tbl_wr_en) begin
            tbl_mem[tbl_wr_addr] <= tbl_wr_data;
        end
        s2_entry      <= tbl_mem[rd_addr];
        s2_func       <= rd_func;
        s2_rss_enable <= s1_rss_enable;
        s2_data       <= s1_data;
        s2_last       <= s1_last;
    end

    // ================================================
    // Stage 2, base plus entry
    // ================================================

    always_ff @(posedge core_clk) begin
        s3_qid  <= s2_rss_enable ? base_qid[s2_func] + s2_entry : base_qid[s2_func];
        s3_data <= s2_data;
        s3_last <= s2_last;
    end

    // Valid and sop through both stages
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
            s2_sop   <= 1'b0;
            s3_valid <= 1'b0;
            s3_sop   <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_sop   <= s1_sop;
            s3_valid <= s2_valid;
            s3_sop   <= s2_sop;
        end
    end

endmodule

/* hw/hash2qid_in_stage.sv */
`timescale 1ns/1ps

module hash2qid_in_stage
    import hash2qid_pkg::*;
#(
    parameter int DATA_WID = 64
) (
    input  logic                  core_clk,
    input  logic                  arst_n,

    input  logic                  in_valid,
    input  logic [DATA_WID-1:0]   in_data,
    input  logic                  in_last,
    input  logic                  in_rss_enable,
    input  logic [QID_WID-1:0]    in_rss_entropy,

    output logic                  s1_valid,
    output logic [DATA_WID-1:0]   s1_data,
    output logic                  s1_last,
    output logic                  s1_sop,
    output logic                  s1_rss_enable,
    output logic [QID_WID-1:0]    s1_entropy
);

    // Next valid beat starts a packet
    logic sop_pending;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            sop_pending <= 1'b1;
            s1_valid    <= 1'b0;
            s1_sop      <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s1_sop   <= in_valid & sop_pending;
            if (in_valid) begin
                sop_pending <= in_last;
            end
        end
    end

    // Beat payload, metadata only kept from the first beat
    always_ff @(posedge core_clk) begin
        s1_data       <= in_data;
        s1_last       <= in_last;
        s1_rss_enable <= sop_pending ? in_rss_enable  : 1'b0;
        s1_entropy    <= sop_pending ? in_rss_entropy : '0;
    end

endmodule

/* hw/hash2qid_regs.sv */
`timescale 1ns/1ps

module hash2qid_regs
    import hash2qid_pkg::*;
(
    input  logic                                core_clk,
    input  logic                                arst_n,

    // Plain write strobe from software
    input  logic                                reg_wr_en,
    input  logic [REG_ADDR_WID-1:0]             reg_wr_addr,
    input  logic [QID_WID-1:0]                  reg_wr_data,

    // Base queue id per function, level signals
    output logic [NUM_FUNCS-1:0][QID_WID-1:0]   base_qid,

    // Forwarded table write
    output logic                                tbl_wr_en,
    output logic [TBL_ADDR_WID-1:0]             tbl_wr_addr,
    output logic [QID_WID-1:0]                  tbl_wr_data
);

    reg_region_e           wr_region;
    logic [FUNC_WID-1:0]   base_sel;
    logic                  base_wr;
    logic                  tbl_wr;

    // ================================================
    // Address decode
    // ================================================

    assign wr_region = reg_region_e'(reg_wr_addr[REG_REGION_BIT]);
    assign base_sel  = reg_wr_addr[FUNC_WID-1:0];

    always_comb begin
        base_wr = 1'b0;
        tbl_wr  = 1'b0;
        if (reg_wr_en) begin
            case (wr_region)
                REGION_BASE:  base_wr = 1'b1;
                REGION_TABLE: tbl_wr  = 1'b1;
                default:      ;
            endcase
        end
    end

    // ================================================
    // Base queue ids
    // ================================================

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            base_qid <= '0;
        end else if (base_wr) begin
            base_qid[base_sel] <= reg_wr_data;
        end
    end

    // ================================================
    // Table write forwarding
    // ================================================

    // Strobe is one cycle, memory sees it on the next edge
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            tbl_wr_en <= 1'b0;
        end else begin
            tbl_wr_en <= tbl_wr;
        end
    end

    // Address and data only matter while tbl_wr_en is high
    always_ff @(posedge core_clk) begin
        if (tbl_wr) begin
            tbl_wr_addr <= reg_wr_addr[TBL_ADDR_WID-1:0];
            tbl_wr_data <= reg_wr_data;
        end
    end

endmodule

/* hw/hash2qid_pkg.sv */
package hash2qid_pkg;

    // ================================================
    // Widths
    // ================================================

    // Queue id and RSS entropy share one width
    localparam int QID_WID   = 12;

    // Function select, entropy bits 11:10
    localparam int FUNC_WID  = 2;
    localparam int NUM_FUNCS = 4;

    // Table index, entropy bits 6:0
    localparam int IDX_WID   = 7;

    // Bit positions inside the entropy field
    localparam int ENT_FUNC_LSB = 10;
    localparam int ENT_IDX_LSB  = 0;

    // ================================================
    // Register map
    // ================================================

    localparam int REG_ADDR_WID = 10;

    // Address bit 9 picks table entry or base queue id
    localparam int REG_REGION_BIT = 9;

    // Table write address is {function, index}
    localparam int TBL_ADDR_WID = FUNC_WID + IDX_WID;
    localparam int TBL_DEPTH    = NUM_FUNCS << IDX_WID;

    typedef enum logic {
        REGION_TABLE = 1'b0,
        REGION_BASE  = 1'b1
    } reg_region_e;

endpackage
